//--- filelist.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_issue_queue.sv
rtl/load_unit.sv
rtl/store_unit.sv
rtl/lsu_top.sv
test/lsu_sva.sv
test/lsu_tb.sv

//--- rtl/load_unit.sv
/*
 * Load unit. Issues a read for an aligned load at the queue head and
 * pops it on grant. Two stages follow: the first holds the request
 * while memory answers, the second picks and extends the bytes.
 * Results leave two cycles after the grant or the misaligned pop.
 */

`include "lsu_macros.svh"

module load_unit import lsu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  lsu_ctrl_t            ctrl_i,
    output logic                 pop_o,

    output mem_rd_req_t          mem_rd_o,
    input  logic                 mem_rd_gnt_i,
    input  logic [`LSU_XLEN-1:0] mem_rdata_i,

    output lsu_result_t          result_o
);

    logic                          is_load;

    // stage one
    logic                          s1_valid_q;
    logic [`LSU_TRANS_ID_BITS-1:0] s1_trans_id_q;
    lsu_op_e                       s1_op_q;
    logic [2:0]                    s1_offset_q;
    lsu_ex_t                       s1_ex_q;

    // stage two
    logic [`LSU_XLEN-1:0]          shifted;
    logic [`LSU_XLEN-1:0]          ld_data;
    lsu_result_t                   res_q;

    assign is_load = ctrl_i.valid && (ctrl_i.fu == FU_LOAD);

    // --------------------
    // read request
    assign mem_rd_o.req  = is_load && !ctrl_i.misaligned;
    assign mem_rd_o.addr = {ctrl_i.addr[`LSU_PADDR_BITS-1:3], 3'b000};

    // misaligned loads leave the queue without touching memory
    assign pop_o = is_load && (ctrl_i.misaligned || (mem_rd_o.req && mem_rd_gnt_i));

    // --------------------
    // stage one waits for read data
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= pop_o;
        end
    end

    // exception fields stay zero unless the load is misaligned
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            s1_trans_id_q <= ctrl_i.trans_id;
            s1_op_q       <= ctrl_i.op;
            s1_offset_q   <= ctrl_i.addr[2:0];
            s1_ex_q.valid <= ctrl_i.misaligned;
            s1_ex_q.cause <= ctrl_i.misaligned ? `LSU_CAUSE_LD_MISALIGNED : 4'd0;
            s1_ex_q.tval  <= ctrl_i.misaligned ? ctrl_i.addr : '0;
        end
    end

    // --------------------
    // stage two selects the lanes and extends
    assign shifted = mem_rdata_i >> {s1_offset_q, 3'b000};

    always_comb begin
        case (s1_op_q)
            LB:      ld_data = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
            LBU:     ld_data = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
            LH:      ld_data = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
            LHU:     ld_data = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
            LW:      ld_data = {{(`LSU_XLEN-32){shifted[31]}}, shifted[31:0]};
            LWU:     ld_data = {{(`LSU_XLEN-32){1'b0}}, shifted[31:0]};
            default: ld_data = shifted;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_q.valid <= 1'b0;
        end else begin
            res_q.valid    <= s1_valid_q;
            res_q.trans_id <= s1_trans_id_q;
            res_q.data     <= s1_ex_q.valid ? '0 : ld_data;
            res_q.ex       <= s1_ex_q;
        end
    end

    assign result_o = res_q;

endmodule

//--- rtl/lsu_agu.sv
/*
 * Address generation for the load/store unit. Turns an issue request
 * into the control record of the queue in the same cycle: effective
 * address, owning unit, byte enable and the misaligned flag.
 */

`include "lsu_macros.svh"

module lsu_agu import lsu_pkg::*; (
    input  lsu_req_t  req_i,
    input  logic      valid_i,
    output lsu_ctrl_t ctrl_o
);

    logic [`LSU_XLEN-1:0]    addr;
    logic [1:0]              size;
    logic [`LSU_BE_BITS-1:0] size_mask;
    logic                    misaligned;

    // imm arrives already sign extended
    assign addr = $unsigned($signed(req_i.base) + $signed(req_i.imm));

    // --------------------
    // log2 of the bytes touched
    always_comb begin
        case (req_i.op)
            LB, LBU, SB: size = 2'd0;
            LH, LHU, SH: size = 2'd1;
            LW, LWU, SW: size = 2'd2;
            default:     size = 2'd3;
        endcase
    end

    always_comb begin
        case (size)
            2'd0:    size_mask = 8'h01;
            2'd1:    size_mask = 8'h03;
            2'd2:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // low address bits must be clear for the size
    always_comb begin
        case (size)
            2'd1:    misaligned = addr[0];
            2'd2:    misaligned = |addr[1:0];
            2'd3:    misaligned = |addr[2:0];
            default: misaligned = 1'b0;
        endcase
    end

    // --------------------
    // control record
    always_comb begin
        ctrl_o.valid      = valid_i;
        ctrl_o.fu         = (req_i.op inside {SB, SH, SW, SD}) ? FU_STORE : FU_LOAD;
        ctrl_o.op         = req_i.op;
        ctrl_o.addr       = addr;
        ctrl_o.data       = req_i.data;
        ctrl_o.be         = size_mask << addr[2:0];
        ctrl_o.misaligned = misaligned;
        ctrl_o.trans_id   = req_i.trans_id;
    end

endmodule

//--- rtl/lsu_issue_queue.sv
/*
 * Two-entry bypass queue between the address unit and the load and
 * store units. An empty queue passes the incoming record straight to
 * the head; otherwise the oldest stored record is shown until a unit pops it.
 */

`include "lsu_macros.svh"

module lsu_issue_queue import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,

    input  lsu_ctrl_t ctrl_i,
    input  logic      pop_ld_i,
    input  logic      pop_st_i,

    output lsu_ctrl_t ctrl_o,
    output logic      ready_o
);

    localparam int unsigned ptr_w = $clog2(`LSU_QUEUE_DEPTH);

    lsu_ctrl_t        mem_q [`LSU_QUEUE_DEPTH];
    logic [ptr_w-1:0] rd_ptr_q;
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w:0]   cnt_q;

    logic push;
    logic pop;
    logic empty;

    assign push  = ctrl_i.valid;
    assign pop   = pop_ld_i | pop_st_i;
    assign empty = (cnt_q == '0);

    // --------------------
    // pointers and fill level
    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // every valid record is stored even if popped on arrival
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= ctrl_i;
        end
    end

    // --------------------
    // head and issue ready
    always_comb begin
        if (empty) begin
            ctrl_o = ctrl_i;
        end else begin
            ctrl_o = mem_q[rd_ptr_q];
        end
    end

    assign ready_o = empty;

endmodule

//--- rtl/lsu_macros.svh
/*
 * Global widths and constants of the load/store unit.
 * Include this wherever a width or an exception cause code is needed.
 */

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// --------------------
// datapath widths
`define LSU_XLEN          64
`define LSU_TRANS_ID_BITS 3
`define LSU_PADDR_BITS    32
`define LSU_BE_BITS       8

// issue queue depth must be a power of two
`define LSU_QUEUE_DEPTH   2

// --------------------
// exception cause codes
`define LSU_CAUSE_LD_MISALIGNED 4'd4
`define LSU_CAUSE_ST_MISALIGNED 4'd6

`endif

//--- rtl/lsu_pkg.sv
/*
 * Shared types of the load/store unit: the operation encoding,
 * the issue request, the queued control record, results and the
 * two memory request records. Modules import it in their header.
 */

`include "lsu_macros.svh"

package lsu_pkg;

    // load and store operations
    typedef enum logic [3:0] {
        LB  = 4'd0,
        LBU = 4'd1,
        LH  = 4'd2,
        LHU = 4'd3,
        LW  = 4'd4,
        LWU = 4'd5,
        LD  = 4'd6,
        SB  = 4'd7,
        SH  = 4'd8,
        SW  = 4'd9,
        SD  = 4'd10
    } lsu_op_e;

    // unit that owns a record
    typedef enum logic {
        FU_LOAD  = 1'b0,
        FU_STORE = 1'b1
    } lsu_fu_e;

    // --------------------
    // issue side
    typedef struct packed {
        lsu_op_e                        op;
        logic [`LSU_XLEN-1:0]           base;
        logic [`LSU_XLEN-1:0]           imm;
        logic [`LSU_XLEN-1:0]           data;
        logic [`LSU_TRANS_ID_BITS-1:0]  trans_id;
    } lsu_req_t;

    // record held in the issue queue
    typedef struct packed {
        logic                           valid;
        lsu_fu_e                        fu;
        lsu_op_e                        op;
        logic [`LSU_XLEN-1:0]           addr;
        logic [`LSU_XLEN-1:0]           data;
        logic [`LSU_BE_BITS-1:0]        be;
        logic                           misaligned;
        logic [`LSU_TRANS_ID_BITS-1:0]  trans_id;
    } lsu_ctrl_t;

    // --------------------
    // writeback side
    typedef struct packed {
        logic                           valid;
        logic [3:0]                     cause;
        logic [`LSU_XLEN-1:0]           tval;
    } lsu_ex_t;

    typedef struct packed {
        logic                           valid;
        logic [`LSU_TRANS_ID_BITS-1:0]  trans_id;
        logic [`LSU_XLEN-1:0]           data;
        lsu_ex_t                        ex;
    } lsu_result_t;

    // --------------------
    // memory ports with word-aligned addresses
    typedef struct packed {
        logic                           req;
        logic [`LSU_PADDR_BITS-1:0]     addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic                           req;
        logic [`LSU_PADDR_BITS-1:0]     addr;
        logic [`LSU_XLEN-1:0]           wdata;
        logic [`LSU_BE_BITS-1:0]        be;
    } mem_wr_req_t;

endpackage

//--- rtl/lsu_top.sv
/*
 * Top level of the load/store unit. The address unit feeds the bypass
 * queue, whose head is shared by the load and store units. Loads and
 * stores write back on their own result ports and use separate memory ports.
 */

`include "lsu_macros.svh"

module lsu_top import lsu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    // issue
    input  logic                 lsu_valid_i,
    input  lsu_req_t             lsu_req_i,
    output logic                 lsu_ready_o,

    // writeback
    output lsu_result_t          load_o,
    output lsu_result_t          store_o,

    // memory
    output mem_rd_req_t          mem_rd_o,
    input  logic                 mem_rd_gnt_i,
    input  logic [`LSU_XLEN-1:0] mem_rdata_i,
    output mem_wr_req_t          mem_wr_o,
    input  logic                 mem_wr_gnt_i
);

    lsu_ctrl_t agu_ctrl;
    lsu_ctrl_t head_ctrl;
    logic      pop_ld;
    logic      pop_st;

    // --------------------
    // address generation
    lsu_agu u_agu (
        .req_i   (lsu_req_i),
        .valid_i (lsu_valid_i),
        .ctrl_o  (agu_ctrl)
    );

    lsu_issue_queue u_queue (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .ctrl_i   (agu_ctrl),
        .pop_ld_i (pop_ld),
        .pop_st_i (pop_st),
        .ctrl_o   (head_ctrl),
        .ready_o  (lsu_ready_o)
    );

    // --------------------
    // load and store units
    load_unit u_load (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ctrl_i       (head_ctrl),
        .pop_o        (pop_ld),
        .mem_rd_o     (mem_rd_o),
        .mem_rd_gnt_i (mem_rd_gnt_i),
        .mem_rdata_i  (mem_rdata_i),
        .result_o     (load_o)
    );

    store_unit u_store (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ctrl_i       (head_ctrl),
        .pop_o        (pop_st),
        .mem_wr_o     (mem_wr_o),
        .mem_wr_gnt_i (mem_wr_gnt_i),
        .result_o     (store_o)
    );

endmodule

//--- rtl/store_unit.sv
/*
 * Store unit. Places the store data into the byte lanes of its address
 * and requests a write with the byte enable of the record. The head is
 * popped on grant, or at once when misaligned, and the result follows
 * one cycle later.
 */

`include "lsu_macros.svh"

module store_unit import lsu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,

    input  lsu_ctrl_t   ctrl_i,
    output logic        pop_o,

    output mem_wr_req_t mem_wr_o,
    input  logic        mem_wr_gnt_i,

    output lsu_result_t result_o
);

    logic        is_store;
    lsu_result_t res_q;

    assign is_store = ctrl_i.valid && (ctrl_i.fu == FU_STORE);

    // --------------------
    // write request
    // low bytes of the operand move up to the addressed lane
    always_comb begin
        mem_wr_o.req   = is_store && !ctrl_i.misaligned;
        mem_wr_o.addr  = {ctrl_i.addr[`LSU_PADDR_BITS-1:3], 3'b000};
        mem_wr_o.wdata = ctrl_i.data << {ctrl_i.addr[2:0], 3'b000};
        mem_wr_o.be    = ctrl_i.be;
    end

    assign pop_o = is_store && (ctrl_i.misaligned || (mem_wr_o.req && mem_wr_gnt_i));

    // --------------------
    // result follows the pop by one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_q.valid <= 1'b0;
        end else begin
            res_q.valid <= pop_o;
            if (pop_o) begin
                res_q.trans_id <= ctrl_i.trans_id;
                res_q.data     <= '0;
                res_q.ex.valid <= ctrl_i.misaligned;
                // cause and trap value only mean something on a misaligned store
                res_q.ex.cause <= ctrl_i.misaligned ? `LSU_CAUSE_ST_MISALIGNED : 4'd0;
                res_q.ex.tval  <= ctrl_i.misaligned ? ctrl_i.addr : '0;
            end
        end
    end

    assign result_o = res_q;

endmodule

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module lsu_tb -o lsu_sim &&
./obj_dir/lsu_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- test/lsu_sva.sv
/*
 * Port-level assertions of the load/store unit, bound to lsu_top
 * by the testbench. Memory request stability, the ready rule and
 * the fixed load latency after a read grant.
 */

`include "lsu_macros.svh"

module lsu_sva import lsu_pkg::*; (
    input logic        clk_i,
    input logic        rst_ni,
    input logic        lsu_ready_o,
    input lsu_result_t load_o,
    input mem_rd_req_t mem_rd_o,
    input logic        mem_rd_gnt_i,
    input mem_wr_req_t mem_wr_o,
    input logic        mem_wr_gnt_i
);

    // --------------------
    // requests hold until granted
    rd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rd_o.req && !mem_rd_gnt_i |=> $stable(mem_rd_o))
        else $error("read request changed before its grant");

    wr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_wr_o.req && !mem_wr_gnt_i |=> $stable(mem_wr_o))
        else $error("write request changed before its grant");

    // --------------------
    // issue side
    // a held record is always an aligned access waiting for memory
    ready_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !lsu_ready_o |-> (mem_rd_o.req || mem_wr_o.req))
        else $error("ready low with no memory request pending");

    // --------------------
    // load latency
    rd_to_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rd_o.req && mem_rd_gnt_i |-> ##2 load_o.valid)
        else $error("no load result two cycles after a read grant");

    result_from_rd: assert property (@(posedge clk_i) disable iff (!rst_ni)
        load_o.valid && !load_o.ex.valid |-> $past(mem_rd_o.req && mem_rd_gnt_i, 2))
        else $error("load result without a read grant two cycles before");

endmodule

//--- test/lsu_tb.sv
/*
 * Testbench of the load/store unit. A 256-word memory with random grants
 * serves both ports. Expected results come from a reference model over a
 * shadow memory kept in issue order and are compared as results leave.
 */

`include "lsu_macros.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int RST_CYCLES  = 10;
    localparam int DRIVE_DLY   = 2;
    localparam int N_DIRECTED  = 23;
    localparam int N_RANDOM    = 120;
    localparam int CYCLE_LIMIT = RST_CYCLES + (N_DIRECTED + N_RANDOM) * 20;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 lsu_valid_i;
    lsu_req_t             lsu_req_i;
    logic                 lsu_ready_o;
    lsu_result_t          load_o;
    lsu_result_t          store_o;
    mem_rd_req_t          mem_rd_o;
    logic                 mem_rd_gnt_i;
    logic [`LSU_XLEN-1:0] mem_rdata_i;
    mem_wr_req_t          mem_wr_o;
    logic                 mem_wr_gnt_i;

    // memory model and its copy updated in issue order
    logic [63:0] mem [256];
    logic [63:0] shadow [256];
    logic [63:0] rd_word;
    logic        rd_pending;

    lsu_result_t exp_load_q [$];
    lsu_result_t exp_store_q [$];
    int unsigned grant_cycles [$];
    int unsigned cycle_cnt;
    int unsigned rd_fires;
    int unsigned wr_fires;
    int unsigned exp_rd_fires;
    int unsigned exp_wr_fires;
    logic [15:0] stim_lfsr;
    logic [15:0] gnt_lfsr;
    logic [2:0]  next_tid;

    lsu_top DUT (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .lsu_valid_i  (lsu_valid_i),
        .lsu_req_i    (lsu_req_i),
        .lsu_ready_o  (lsu_ready_o),
        .load_o       (load_o),
        .store_o      (store_o),
        .mem_rd_o     (mem_rd_o),
        .mem_rd_gnt_i (mem_rd_gnt_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_wr_o     (mem_wr_o),
        .mem_wr_gnt_i (mem_wr_gnt_i)
    );

    bind lsu_top lsu_sva u_sva (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .lsu_ready_o  (lsu_ready_o),
        .load_o       (load_o),
        .mem_rd_o     (mem_rd_o),
        .mem_rd_gnt_i (mem_rd_gnt_i),
        .mem_wr_o     (mem_wr_o),
        .mem_wr_gnt_i (mem_wr_gnt_i)
    );

    always #20 clk_i = ~clk_i;

    // --------------------
    // failure reporting
    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] want);
        assert (got === want) else
            report_fail($sformatf("mismatch at time %0t: %s got %h expected %h",
                                  $time, name, got, want));
    endtask

    task automatic check_result(string port, lsu_result_t got, lsu_result_t want);
        check_value({port, ".trans_id"}, 64'(got.trans_id), 64'(want.trans_id));
        check_value({port, ".data"}, got.data, want.data);
        check_value({port, ".ex.valid"}, 64'(got.ex.valid), 64'(want.ex.valid));
        check_value({port, ".ex.cause"}, 64'(got.ex.cause), 64'(want.ex.cause));
        check_value({port, ".ex.tval"}, got.ex.tval, want.ex.tval);
    endtask

    // --------------------
    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int n, output logic [15:0] value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            state = lfsr_next(state);
            value = {value[14:0], state[0]};
        end
    endtask

    // --------------------
    // reference model
    function automatic int access_bytes(lsu_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic bit is_store_op(lsu_op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

    function automatic bit is_misaligned(lsu_op_e op, logic [63:0] addr);
        return (addr[2:0] & 3'(access_bytes(op) - 1)) != 3'd0;
    endfunction

    function automatic logic [63:0] fill_word(int idx);
        return 64'h9e37_79b9_7f4a_7c15 * 64'(idx + 1);
    endfunction

    function automatic lsu_result_t expected_result(lsu_op_e op, logic [63:0] addr,
                                                    logic [2:0] tid);
        lsu_result_t r;
        logic [63:0] word;
        logic [63:0] val;
        int          n;
        int          i;
        n          = access_bytes(op);
        r          = '0;
        r.valid    = 1'b1;
        r.trans_id = tid;
        if (is_misaligned(op, addr)) begin
            r.ex.valid = 1'b1;
            r.ex.cause = is_store_op(op) ? `LSU_CAUSE_ST_MISALIGNED : `LSU_CAUSE_LD_MISALIGNED;
            r.ex.tval  = addr;
        end else if (!is_store_op(op)) begin
            word = shadow[addr[10:3]];
            val  = '0;
            for (i = 0; i < n; i++) begin
                val[8*i +: 8] = word[8*(int'(addr[2:0]) + i) +: 8];
            end
            // signed loads copy the top loaded bit upward
            if ((op inside {LB, LH, LW}) && val[8*n-1]) begin
                for (i = n; i < 8; i++) begin
                    val[8*i +: 8] = 8'hff;
                end
            end
            r.data = val;
        end
        return r;
    endfunction

    task automatic shadow_write(lsu_op_e op, logic [63:0] addr, logic [63:0] data);
        int i;
        for (i = 0; i < access_bytes(op); i++) begin
            shadow[addr[10:3]][8*(int'(addr[2:0]) + i) +: 8] = data[8*i +: 8];
        end
    endtask

    // --------------------
    // drives one operation and queues its expected result
    task automatic issue_op(lsu_op_e op, logic [63:0] base, logic [63:0] imm,
                            logic [63:0] data);
        logic [63:0] addr;
        addr = base + imm;
        while (!lsu_ready_o) begin
            @(posedge clk_i);
            #DRIVE_DLY;
        end
        lsu_req_i.op       = op;
        lsu_req_i.base     = base;
        lsu_req_i.imm      = imm;
        lsu_req_i.data     = data;
        lsu_req_i.trans_id = next_tid;
        lsu_valid_i        = 1'b1;
        if (is_store_op(op)) begin
            exp_store_q.push_back(expected_result(op, addr, next_tid));
            if (!is_misaligned(op, addr)) begin
                shadow_write(op, addr, data);
                exp_wr_fires++;
            end
        end else begin
            exp_load_q.push_back(expected_result(op, addr, next_tid));
            if (!is_misaligned(op, addr)) begin
                exp_rd_fires++;
            end
        end
        next_tid++;
        @(posedge clk_i);
        #DRIVE_DLY;
        lsu_valid_i = 1'b0;
    endtask

    // --------------------
    // cycle count and run limit
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        assert (cycle_cnt < CYCLE_LIMIT) else
            report_fail("timeout: the operations did not finish within the cycle limit");
    end

    // grants and read data driven after the edge
    always @(posedge clk_i) begin
        logic [15:0] bits;
        #DRIVE_DLY;
        mem_rdata_i = rd_pending ? rd_word : '0;
        rd_pending  = 1'b0;
        draw_bits(gnt_lfsr, 1, bits);
        mem_rd_gnt_i = bits[0];
        draw_bits(gnt_lfsr, 1, bits);
        mem_wr_gnt_i = bits[0];
    end

    // memory side sampled mid cycle
    always @(negedge clk_i) begin
        int b;
        if (rst_ni && mem_rd_o.req && mem_rd_gnt_i) begin
            rd_word    = mem[mem_rd_o.addr[10:3]];
            rd_pending = 1'b1;
            grant_cycles.push_back(cycle_cnt);
            rd_fires++;
        end
        if (rst_ni && mem_wr_o.req && mem_wr_gnt_i) begin
            for (b = 0; b < 8; b++) begin
                if (mem_wr_o.be[b]) begin
                    mem[mem_wr_o.addr[10:3]][8*b +: 8] = mem_wr_o.wdata[8*b +: 8];
                end
            end
            wr_fires++;
        end
    end

    // compare results against the expected queues
    always @(negedge clk_i) begin
        lsu_result_t want;
        int unsigned g;
        if (rst_ni && load_o.valid) begin
            assert (exp_load_q.size() != 0) else
                report_fail("a load result arrived with no load outstanding");
            want = exp_load_q.pop_front();
            check_result("load_o", load_o, want);
            if (!want.ex.valid) begin
                g = grant_cycles.pop_front();
                check_value("load_o latency", 64'(cycle_cnt - g), 64'd2);
            end
        end
        if (rst_ni && store_o.valid) begin
            assert (exp_store_q.size() != 0) else
                report_fail("a store result arrived with no store outstanding");
            want = exp_store_q.pop_front();
            check_result("store_o", store_o, want);
        end
    end

    // --------------------
    // stimulus
    initial begin
        int          k;
        logic [15:0] r_op;
        logic [15:0] r_imm;
        logic [15:0] r_al;
        logic [15:0] r_d [4];
        lsu_op_e     op;
        logic [63:0] imm;
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        lsu_valid_i  = 1'b0;
        lsu_req_i    = '0;
        mem_rd_gnt_i = 1'b0;
        mem_wr_gnt_i = 1'b0;
        mem_rdata_i  = '0;
        rd_pending   = 1'b0;
        cycle_cnt    = 0;
        rd_fires     = 0;
        wr_fires     = 0;
        exp_rd_fires = 0;
        exp_wr_fires = 0;
        stim_lfsr    = 16'd6;
        gnt_lfsr     = 16'd6;
        next_tid     = '0;
        for (k = 0; k < 256; k++) begin
            mem[k]    = fill_word(k);
            shadow[k] = mem[k];
        end

        repeat (RST_CYCLES) @(posedge clk_i);
        #DRIVE_DLY;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_value("lsu_ready_o", 64'(lsu_ready_o), 64'd1);
        check_value("load_o.valid", 64'(load_o.valid), 64'd0);
        check_value("store_o.valid", 64'(store_o.valid), 64'd0);
        check_value("mem_rd_o.req", 64'(mem_rd_o.req), 64'd0);
        check_value("mem_wr_o.req", 64'(mem_wr_o.req), 64'd0);
        @(posedge clk_i);
        #DRIVE_DLY;

        // stores of every size into one word
        issue_op(SD, 64'h20, 64'd0, 64'h0123_4567_89ab_cdef);
        issue_op(SB, 64'h40, -64'd31, 64'h0000_0000_0000_0080);
        issue_op(SH, 64'h20, 64'd2, 64'h0000_0000_0000_f00d);
        issue_op(SW, 64'h20, 64'd4, 64'h1111_2222_8bad_f00d);
        // loads of every size, signed and unsigned
        issue_op(LB, 64'h20, 64'd1, '0);
        issue_op(LBU, 64'h20, 64'd1, '0);
        issue_op(LH, 64'h20, 64'd2, '0);
        issue_op(LHU, 64'h20, 64'd2, '0);
        issue_op(LW, 64'h20, 64'd4, '0);
        issue_op(LWU, 64'h20, 64'd4, '0);
        issue_op(LD, 64'h20, 64'd0, '0);
        issue_op(LB, 64'h20, 64'd7, '0);
        issue_op(LH, 64'h20, 64'd6, '0);
        // misaligned accesses
        issue_op(LH, 64'h30, 64'd1, '0);
        issue_op(LW, 64'h30, 64'd2, '0);
        issue_op(LD, 64'h30, 64'd4, '0);
        issue_op(LHU, 64'h30, 64'd3, '0);
        issue_op(LWU, 64'h20, 64'd6, '0);
        issue_op(SH, 64'h40, 64'd1, 64'hffff_ffff_ffff_ffff);
        issue_op(SW, 64'h40, 64'd3, 64'hffff_ffff_ffff_ffff);
        issue_op(SD, 64'h40, 64'd4, 64'hffff_ffff_ffff_ffff);
        // the misaligned stores must not have touched these
        issue_op(LD, 64'h40, 64'd0, '0);
        issue_op(LD, 64'h30, 64'd0, '0);

        // mostly aligned random mix around 0x400
        for (k = 0; k < N_RANDOM; k++) begin
            draw_bits(stim_lfsr, 4, r_op);
            draw_bits(stim_lfsr, 11, r_imm);
            draw_bits(stim_lfsr, 2, r_al);
            draw_bits(stim_lfsr, 16, r_d[0]);
            draw_bits(stim_lfsr, 16, r_d[1]);
            draw_bits(stim_lfsr, 16, r_d[2]);
            draw_bits(stim_lfsr, 16, r_d[3]);
            op  = lsu_op_e'(4'(r_op % 16'd11));
            imm = {{53{r_imm[10]}}, r_imm[10:0]};
            if (r_al[1:0] != 2'b00) begin
                imm[2:0] = 3'b000;
            end
            issue_op(op, 64'h400, imm, {r_d[0], r_d[1], r_d[2], r_d[3]});
        end

        while (exp_load_q.size() != 0 || exp_store_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (3) @(posedge clk_i);
        check_value("read grants", 64'(rd_fires), 64'(exp_rd_fires));
        check_value("write grants", 64'(wr_fires), 64'(exp_wr_fires));
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
